// ==== build.f ====
+incdir+.
mem_pkg.sv
mem_fifo.sv
mem_core.sv
op_profiler.sv
mem_endpoint.sv
tb_mem_endpoint.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_mem_endpoint
FILELIST  := build.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) tb_mem_tasks.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_mem_tasks.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Driver, compare and directed test tasks; included
// inside the endpoint testbench module.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_resp(input mem_resp_s got, input mem_resp_s exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERR %0t: %s got op %0d data %h tag %h, expected op %0d data %h tag %h",
               $time, what, got.op, got.data, got.tag, exp.op, exp.data, exp.tag);
    end
  endtask

  task automatic check_stat(input mem_stat_s got, input mem_stat_s exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERR %0t: %s got cyc %0d tag %h ld %0d st %0d swp %0d or %0d", $time, what,
               got.cycle, got.tag, got.ld, got.st, got.amoswap, got.amoor);
      $display("ERR %0t: %s expected cyc %0d tag %h ld %0d st %0d swp %0d or %0d", $time,
               what, exp.cycle, exp.tag, exp.ld, exp.st, exp.amoswap, exp.amoor);
    end
  endtask

  function automatic mem_stat_s expected_stat(input logic [ctr_width_lp-1:0] cycle,
                                              input logic [tag_width_lp-1:0] tag);
    mem_stat_s rec;
    rec.cycle   = cycle;
    rec.tag     = tag;
    rec.ld      = model_ld;
    rec.st      = model_st;
    rec.amoswap = model_amoswap;
    rec.amoor   = model_amoor;
    return rec;
  endfunction

  // Every operation answers with the old word; only loads leave memory alone.
  task automatic send_req(input mem_op_e op, input logic [addr_width_lp-1:0] addr,
                          input logic [data_width_lp-1:0] data,
                          input logic [tag_width_lp-1:0] tag);
    mem_resp_s exp_resp;
    logic      taken;
    exp_resp.op   = op;
    exp_resp.data = model_mem[addr];
    exp_resp.tag  = tag;
    exp_q.push_back(exp_resp);
    case (op)
      e_load: model_ld = model_ld + 1;
      e_store: begin
        model_st = model_st + 1;
        model_mem[addr] = data;
      end
      e_amoswap: begin
        model_amoswap = model_amoswap + 1;
        model_mem[addr] = data;
      end
      default: begin
        model_amoor = model_amoor + 1;
        model_mem[addr] = exp_resp.data | data;
      end
    endcase
    @(negedge clk_i);
    req_v_i    = 1'b1;
    req_op_i   = op;
    req_addr_i = addr;
    req_data_i = data;
    req_tag_i  = tag;
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk_i);
      taken = req_ready_o;
      if (!taken) saw_stall = 1'b1;
    end
  endtask

  task automatic end_reqs_and_drain();
    @(negedge clk_i);
    req_v_i = 1'b0;
    while (exp_q.size() != 0) @(posedge clk_i);
  endtask

  task automatic request_stat(input logic [tag_width_lp-1:0] tag,
                              output logic [ctr_width_lp-1:0] at_cycle);
    logic taken;
    @(negedge clk_i);
    stat_req_v_i = 1'b1;
    stat_tag_i   = tag;
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk_i);
      taken    = stat_req_ready_o;
      at_cycle = edge_count;
    end
    @(negedge clk_i);
    stat_req_v_i = 1'b0;
  endtask

  task automatic collect_stat(input int hold_cycles, output mem_stat_s rec);
    do @(posedge clk_i); while (!stat_v_o);
    rec = stat_seen;
    repeat (hold_cycles) begin
      @(posedge clk_i);
      check_stat(stat_seen, rec, "held record");
      if (!stat_v_o || stat_req_ready_o) begin
        err_count++;
        $display("The statistics handshake changed while the record was held.");
      end
    end
    @(negedge clk_i);
    stat_ready_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    stat_ready_i = 1'b0;
  endtask

  task automatic test_store_load();
    send_req(e_store, 6'd5, 32'hcafe_0123, 8'h01);
    send_req(e_load, 6'd5, 32'h0, 8'h02);
    end_reqs_and_drain();
  endtask

  task automatic test_atomics();
    send_req(e_store, 6'd9, 32'h0f0f_0000, 8'h03);
    send_req(e_amoswap, 6'd9, 32'h1234_5678, 8'h04);
    send_req(e_load, 6'd9, 32'h0, 8'h05);
    send_req(e_amoor, 6'd9, 32'h8000_0001, 8'h06);
    send_req(e_load, 6'd9, 32'h0, 8'h07);
    end_reqs_and_drain();
  endtask

  task automatic test_random_stream();
    mem_op_e op;
    random_ready = 1'b1;
    saw_stall    = 1'b0;
    for (int i = 0; i < 40; i++) begin
      op = mem_op_e'(2'($urandom_range(0, 3)));
      send_req(op, addr_width_lp'($urandom_range(0, 7)), $urandom, tag_width_lp'(64 + i));
    end
    random_ready = 1'b0;
    end_reqs_and_drain();
    if (!saw_stall) begin
      err_count++;
      $display("The request queue never pushed back while responses were stalled.");
    end
  endtask

  task automatic test_stat_snapshot();
    mem_op_e                 mix [8] = '{e_load, e_store, e_load, e_amoor,
                                         e_amoswap, e_store, e_load, e_amoor};
    logic [ctr_width_lp-1:0] cyc;
    mem_stat_s               rec;
    for (int i = 0; i < 8; i++) begin
      send_req(mix[i], addr_width_lp'(20 + i), 32'h0101_0000 + i, tag_width_lp'(128 + i));
    end
    end_reqs_and_drain();
    request_stat(8'ha5, cyc);
    collect_stat(5, rec);
    check_stat(rec, expected_stat(cyc, 8'ha5), "snapshot");
  endtask

  task automatic test_two_snapshots();
    logic [ctr_width_lp-1:0] cyc1, cyc2;
    mem_stat_s               rec1, rec2;
    request_stat(8'h31, cyc1);
    collect_stat(0, rec1);
    check_stat(rec1, expected_stat(cyc1, 8'h31), "first snapshot");
    send_req(e_load, 6'd3, 32'h0, 8'hc0);
    send_req(e_amoor, 6'd3, 32'h0000_00ff, 8'hc1);
    end_reqs_and_drain();
    request_stat(8'h32, cyc2);
    collect_stat(0, rec2);
    check_stat(rec2, expected_stat(cyc2, 8'h32), "second snapshot");
    if (rec2.ld < rec1.ld || rec2.st < rec1.st || rec2.amoswap < rec1.amoswap ||
        rec2.amoor < rec1.amoor || (rec2.cycle - rec1.cycle) < (cyc2 - cyc1)) begin
      err_count++;
      $display("ERR %0t: second snapshot fell behind the first", $time);
    end
  endtask

// ==== tb_mem_endpoint.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the remote-memory endpoint; runs
// the directed tests from the included task header.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_mem_endpoint
  import mem_pkg::*;
  ();

  localparam int reset_cycles_lp    = 8;
  localparam int directed_cycles_lp = 150;
  localparam int stream_cycles_lp   = 400;
  localparam int test_cycles_lp     = reset_cycles_lp + directed_cycles_lp + stream_cycles_lp;
  localparam int watchdog_ns_lp     = test_cycles_lp * 4 * 2;

  logic                     clk_i;
  logic                     reset_i;
  logic                     req_v_i;
  mem_op_e                  req_op_i;
  logic [addr_width_lp-1:0] req_addr_i;
  logic [data_width_lp-1:0] req_data_i;
  logic [tag_width_lp-1:0]  req_tag_i;
  logic                     req_ready_o;
  logic                     resp_v_o;
  mem_op_e                  resp_op_o;
  logic [data_width_lp-1:0] resp_data_o;
  logic [tag_width_lp-1:0]  resp_tag_o;
  logic                     resp_ready_i = 1'b1;
  logic                     stat_req_v_i;
  logic [tag_width_lp-1:0]  stat_tag_i;
  logic                     stat_req_ready_o;
  logic                     stat_v_o;
  logic [ctr_width_lp-1:0]  stat_cycle_o;
  logic [tag_width_lp-1:0]  stat_tag_o;
  logic [ctr_width_lp-1:0]  stat_ld_o;
  logic [ctr_width_lp-1:0]  stat_st_o;
  logic [ctr_width_lp-1:0]  stat_amoswap_o;
  logic [ctr_width_lp-1:0]  stat_amoor_o;
  logic                     stat_ready_i;

  // Model state is updated as each request is handed over.
  logic [data_width_lp-1:0] model_mem [mem_words_lp];
  logic [ctr_width_lp-1:0]  model_ld, model_st, model_amoswap, model_amoor;
  logic [ctr_width_lp-1:0]  edge_count;
  mem_resp_s                exp_q [$];
  mem_resp_s                resp_seen;
  mem_stat_s                stat_seen;
  logic                     random_ready;
  logic                     saw_stall;
  int                       err_count;
  int                       check_count;

  assign resp_seen = {resp_op_o, resp_data_o, resp_tag_o};
  assign stat_seen = {stat_cycle_o, stat_tag_o, stat_ld_o, stat_st_o,
                      stat_amoswap_o, stat_amoor_o};

  mem_endpoint i_dut (.*);

  `include "tb_mem_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Counts clock edges since reset for the expected cycle field.
  always @(posedge clk_i) begin
    if (reset_i) edge_count <= '0;
    else edge_count <= edge_count + 1;
  end

  always @(negedge clk_i) begin
    resp_ready_i = random_ready ? ($urandom_range(0, 3) == 0) : 1'b1;
  end

  always @(posedge clk_i) begin : resp_monitor
    mem_resp_s exp_resp;
    if (!reset_i && resp_v_o && resp_ready_i) begin
      if (exp_q.size() == 0) begin
        err_count++;
        $display("A response with tag %h arrived with no request outstanding.", resp_tag_o);
      end else begin
        exp_resp = exp_q.pop_front();
        check_resp(resp_seen, exp_resp, "response");
      end
    end
  end

  initial begin : watchdog
    #(watchdog_ns_lp);
    $display("timeout: DUT stopped responding");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : main
    void'($urandom(32'h9b59));
    reset_i      = 1'b1;
    req_v_i      = 1'b0;
    req_op_i     = e_load;
    req_addr_i   = '0;
    req_data_i   = '0;
    req_tag_i    = '0;
    stat_req_v_i = 1'b0;
    stat_tag_i   = '0;
    stat_ready_i = 1'b0;
    random_ready = 1'b0;
    saw_stall    = 1'b0;
    err_count    = 0;
    check_count  = 0;
    model_ld      = '0;
    model_st      = '0;
    model_amoswap = '0;
    model_amoor   = '0;
    for (int i = 0; i < mem_words_lp; i++) model_mem[i] = '0;

    repeat (reset_cycles_lp) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    test_store_load();
    test_atomics();
    test_random_stream();
    test_stat_snapshot();
    test_two_snapshots();
    repeat (4) @(posedge clk_i);

    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== mem_endpoint.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Remote-memory endpoint top: request queue, core,
// response queue and the operation profiler.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mem_endpoint
  import mem_pkg::*;
  (
    input  logic                     clk_i,
    input  logic                     reset_i,

    input  logic                     req_v_i,
    input  mem_op_e                  req_op_i,
    input  logic [addr_width_lp-1:0] req_addr_i,
    input  logic [data_width_lp-1:0] req_data_i,
    input  logic [tag_width_lp-1:0]  req_tag_i,
    output logic                     req_ready_o,

    output logic                     resp_v_o,
    output mem_op_e                  resp_op_o,
    output logic [data_width_lp-1:0] resp_data_o,
    output logic [tag_width_lp-1:0]  resp_tag_o,
    input  logic                     resp_ready_i,

    input  logic                     stat_req_v_i,
    input  logic [tag_width_lp-1:0]  stat_tag_i,
    output logic                     stat_req_ready_o,

    output logic                     stat_v_o,
    output logic [ctr_width_lp-1:0]  stat_cycle_o,
    output logic [tag_width_lp-1:0]  stat_tag_o,
    output logic [ctr_width_lp-1:0]  stat_ld_o,
    output logic [ctr_width_lp-1:0]  stat_st_o,
    output logic [ctr_width_lp-1:0]  stat_amoswap_o,
    output logic [ctr_width_lp-1:0]  stat_amoor_o,
    input  logic                     stat_ready_i
  );

  mem_req_s  req_in, core_req;
  mem_resp_s core_resp, resp_out;
  mem_stat_s stat;
  logic      core_req_v, core_req_ready;
  logic      core_resp_v, core_resp_ready;
  logic      core_accept;

  assign req_in = '{req_op_i, req_addr_i, req_data_i, req_tag_i};

  // The profiler counts at the same strobe the core uses to accept.
  assign core_accept = core_req_v & core_req_ready;

  mem_fifo #(.payload_t(mem_req_s)) i_req_fifo (
    .clk_i, .reset_i,
    .in_v_i(req_v_i), .in_data_i(req_in), .in_ready_o(req_ready_o),
    .out_v_o(core_req_v), .out_data_o(core_req), .out_ready_i(core_req_ready)
  );

  mem_core i_core (
    .clk_i, .reset_i,
    .req_v_i(core_req_v), .req_i(core_req), .req_ready_o(core_req_ready),
    .resp_v_o(core_resp_v), .resp_o(core_resp), .resp_ready_i(core_resp_ready)
  );

  mem_fifo #(.payload_t(mem_resp_s)) i_resp_fifo (
    .clk_i, .reset_i,
    .in_v_i(core_resp_v), .in_data_i(core_resp), .in_ready_o(core_resp_ready),
    .out_v_o(resp_v_o), .out_data_o(resp_out), .out_ready_i(resp_ready_i)
  );

  op_profiler i_profiler (
    .clk_i, .reset_i,
    .acc_v_i(core_accept), .acc_op_i(core_req.op),
    .stat_req_v_i, .stat_tag_i, .stat_req_ready_o,
    .stat_v_o, .stat_o(stat), .stat_ready_i
  );

  assign resp_op_o   = resp_out.op;
  assign resp_data_o = resp_out.data;
  assign resp_tag_o  = resp_out.tag;

  assign stat_cycle_o   = stat.cycle;
  assign stat_tag_o     = stat.tag;
  assign stat_ld_o      = stat.ld;
  assign stat_st_o      = stat.st;
  assign stat_amoswap_o = stat.amoswap;
  assign stat_amoor_o   = stat.amoor;

endmodule

// ==== op_profiler.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Counts accepted requests by operation and hands
// out a tagged snapshot on each statistics request.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module op_profiler
  import mem_pkg::*;
  (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  logic                    acc_v_i,
    input  mem_op_e                 acc_op_i,

    input  logic                    stat_req_v_i,
    input  logic [tag_width_lp-1:0] stat_tag_i,
    output logic                    stat_req_ready_o,

    output logic                    stat_v_o,
    output mem_stat_s               stat_o,
    input  logic                    stat_ready_i
  );

  logic [ctr_width_lp-1:0] cycle_r;
  logic [ctr_width_lp-1:0] ld_r, st_r, amoswap_r, amoor_r;
  logic                    stat_v_r;
  mem_stat_s               stat_r;
  logic                    take_snap;

  assign stat_req_ready_o = ~stat_v_r;
  assign take_snap        = stat_req_v_i & stat_req_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cycle_r   <= '0;
      ld_r      <= '0;
      st_r      <= '0;
      amoswap_r <= '0;
      amoor_r   <= '0;
    end else begin
      cycle_r <= cycle_r + 1'b1;
      if (acc_v_i) begin
        case (acc_op_i)
          e_load:    ld_r      <= ld_r + 1'b1;
          e_store:   st_r      <= st_r + 1'b1;
          e_amoswap: amoswap_r <= amoswap_r + 1'b1;
          default:   amoor_r   <= amoor_r + 1'b1;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stat_v_r <= 1'b0;
    end else if (take_snap) begin
      stat_v_r <= 1'b1;
    end else if (stat_ready_i) begin
      stat_v_r <= 1'b0;
    end
  end

  // The record sees the counts as they stood before this edge.
  always_ff @(posedge clk_i) begin
    if (take_snap) stat_r <= '{cycle_r, stat_tag_i, ld_r, st_r, amoswap_r, amoor_r};
  end

  assign stat_v_o = stat_v_r;
  assign stat_o   = stat_r;

  pending_record_not_overwritten: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (stat_v_o && !stat_ready_i) |=> (stat_v_o && $stable(stat_o))
  ) else $error("statistics record replaced before it was taken");

endmodule

// ==== mem_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Executes load, store and atomic requests on a
// word memory and holds one response in a register.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mem_core
  import mem_pkg::*;
  (
    input  logic      clk_i,
    input  logic      reset_i,

    input  logic      req_v_i,
    input  mem_req_s  req_i,
    output logic      req_ready_o,

    output logic      resp_v_o,
    output mem_resp_s resp_o,
    input  logic      resp_ready_i
  );

  logic [data_width_lp-1:0] mem_r [mem_words_lp];

  logic                     resp_v_r;
  mem_resp_s                resp_r;
  logic                     accept;
  logic [data_width_lp-1:0] old_word;
  logic [data_width_lp-1:0] new_word;
  logic                     write_en;

  // The output register frees up in the same cycle it is drained.
  assign req_ready_o = ~resp_v_r | resp_ready_i;
  assign accept      = req_v_i & req_ready_o;

  assign old_word = mem_r[req_i.addr];

  always_comb begin
    new_word = req_i.data;
    write_en = 1'b1;
    case (req_i.op)
      e_load: begin
        write_en = 1'b0;
      end
      e_amoor: begin
        new_word = old_word | req_i.data;
      end
      default: begin
        new_word = req_i.data;
      end
    endcase
  end

  // Memory contents start from zero after reset.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < mem_words_lp; i++) begin
        mem_r[i] <= '0;
      end
    end else if (accept & write_en) begin
      mem_r[req_i.addr] <= new_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
    end else if (accept) begin
      resp_v_r <= 1'b1;
    end else if (resp_ready_i) begin
      resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_r.op   <= req_i.op;
      resp_r.data <= old_word;
      resp_r.tag  <= req_i.tag;
    end
  end

  assign resp_v_o = resp_v_r;
  assign resp_o   = resp_r;

  resp_held_under_backpressure: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (resp_v_o && !resp_ready_i) |=> (resp_v_o && $stable(resp_o))
  ) else $error("response changed while stalled");

endmodule

// ==== mem_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Small registered queue with valid/ready on both
// sides; the payload type is set per instance.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mem_fifo
  import mem_pkg::*;
  #(parameter type payload_t = logic)
  (
    input  logic     clk_i,
    input  logic     reset_i,

    input  logic     in_v_i,
    input  payload_t in_data_i,
    output logic     in_ready_o,

    output logic     out_v_o,
    output payload_t out_data_o,
    input  logic     out_ready_i
  );

  payload_t mem_r [fifo_depth_lp];

  logic [fifo_ptr_width_lp-1:0] rd_ptr_r, wr_ptr_r;
  logic [fifo_cnt_width_lp-1:0] count_r;
  logic full, push, pop;

  assign full = (count_r == fifo_cnt_width_lp'(fifo_depth_lp));

  // A full queue still takes a word when the head leaves in the same cycle.
  assign in_ready_o = ~full | out_ready_i;
  assign out_v_o    = (count_r != '0);
  assign out_data_o = mem_r[rd_ptr_r];

  assign push = in_v_i & in_ready_o;
  assign pop  = out_v_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) wr_ptr_r <= wr_ptr_r + 1'b1;
      if (pop) rd_ptr_r <= rd_ptr_r + 1'b1;
      if (push & ~pop) count_r <= count_r + 1'b1;
      else if (pop & ~push) count_r <= count_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_r[wr_ptr_r] <= in_data_i;
  end

  count_within_depth: assert property (
    @(posedge clk_i) disable iff (reset_i)
    count_r <= fifo_cnt_width_lp'(fifo_depth_lp)
  ) else $error("fifo count exceeds depth");

endmodule

// ==== mem_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, depths and payload types shared by the
// remote-memory endpoint and its testbench.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mem_pkg;

  localparam int addr_width_lp = 6;
  localparam int data_width_lp = 32;
  localparam int tag_width_lp  = 8;
  localparam int ctr_width_lp  = 32;
  localparam int fifo_depth_lp = 4;

  // Queue pointer and occupancy widths follow from the depth.
  localparam int fifo_ptr_width_lp = $clog2(fifo_depth_lp);
  localparam int fifo_cnt_width_lp = $clog2(fifo_depth_lp + 1);

  localparam int mem_words_lp = 1 << addr_width_lp;

  typedef enum logic [1:0] {
    e_load    = 2'd0,
    e_store   = 2'd1,
    e_amoswap = 2'd2,
    e_amoor   = 2'd3
  } mem_op_e;

  typedef struct packed {
    mem_op_e                  op;
    logic [addr_width_lp-1:0] addr;
    logic [data_width_lp-1:0] data;
    logic [tag_width_lp-1:0]  tag;
  } mem_req_s;

  // The data field carries the word as it was before the operation.
  typedef struct packed {
    mem_op_e                  op;
    logic [data_width_lp-1:0] data;
    logic [tag_width_lp-1:0]  tag;
  } mem_resp_s;

  typedef struct packed {
    logic [ctr_width_lp-1:0] cycle;
    logic [tag_width_lp-1:0] tag;
    logic [ctr_width_lp-1:0] ld;
    logic [ctr_width_lp-1:0] st;
    logic [ctr_width_lp-1:0] amoswap;
    logic [ctr_width_lp-1:0] amoor;
  } mem_stat_s;

endpackage
